//--- verilog/vram_pkg.sv
`default_nettype none

package vram_pkg;

  // --------------------
  // axi4-lite bus geometry
  // --------------------

  // data bus, one 32-bit word per beat
  localparam int axi_data_width = 32;

  // byte address as seen on AWADDR / ARADDR
  localparam int axi_addr_width = 16;

  // one strobe bit per byte lane
  localparam int axi_strb_width = axi_data_width / 8;

  // --------------------
  // vram geometry
  // --------------------

  // byte offset inside a word is dropped, word index starts here
  localparam int addr_lsb = 2;

  // word index width, byte address bits 11..2
  // bits above 11 are ignored so the vram aliases through the window
  localparam int vram_addr_bits = 10;

  // number of 32-bit words in the vram
  localparam int vram_depth = 2 ** vram_addr_bits;

  // --------------------
  // response codes
  // --------------------

  // only OKAY is ever returned
  // every address decodes to some word, so no SLVERR / DECERR
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

//--- verilog/axi_write_channel.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_channel import vram_pkg::*;
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  // write address
  input  logic [axi_addr_width-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  // write data
  input  logic [axi_data_width-1:0] wdata,
  input  logic [axi_strb_width-1:0] wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  // write response
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  // memory write port
  output logic                      wr_en,
  output logic [vram_addr_bits-1:0] wr_addr,
  output logic [axi_data_width-1:0] wr_data,
  output logic [axi_strb_width-1:0] wr_strb
);

  // high while no write is in flight, cleared from acceptance to response
  logic aw_en;
  // address and data both present and the slave is free
  logic accept;

  assign accept = ~awready && awvalid && wvalid && aw_en;

  // --------------------
  // address / data ready
  // --------------------

  // one-cycle pulse on both readies, address and data go together
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_en   <= 1'b1;
    end
    else
    begin
      awready <= accept;
      wready  <= accept;
      // block a second write until the master takes the response
      if (accept)
        aw_en <= 1'b0;
      else if (bvalid && bready)
        aw_en <= 1'b1;
    end
  end

  // latch the word index on the edge that raises the readies
  // byte offset and bits above 11 are dropped here
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
      wr_addr <= awaddr[addr_lsb +: vram_addr_bits];
  end

  // --------------------
  // memory write
  // --------------------

  // data and strobes are still held by the master during the ready cycle
  assign wr_en   = awready && wready && awvalid && wvalid;
  assign wr_data = wdata;
  assign wr_strb = wstrb;

  // --------------------
  // write response
  // --------------------

  // bvalid rises on the edge that closes the ready cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      bvalid <= 1'b0;
      bresp  <= 2'b00;
    end
    else if (wr_en && !bvalid)
    begin
      bvalid <= 1'b1;
      bresp  <= resp_okay;
    end
    else if (bvalid && bready)
      bvalid <= 1'b0;
  end

  // --------------------
  // checks
  // --------------------

  // address and data are always taken in the same cycle
  a_ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    awready == wready);

  // response is held until the master takes it
  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid && !bready |=> bvalid);

  // only one write outstanding, nothing reaches the ram while a response waits
  a_no_write_pending: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    wr_en |-> !bvalid);

endmodule

`default_nettype wire

//--- verilog/axi_read_channel.sv
`timescale 1ns/10ps
`default_nettype none

module axi_read_channel import vram_pkg::*;
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  // read address
  input  logic [axi_addr_width-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  // read response, data comes straight from the ram register
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  // memory read port
  output logic                      rd_en,
  output logic [vram_addr_bits-1:0] rd_addr
);

  // new address only when the previous data has been taken
  logic accept;

  assign accept = ~arready && arvalid && ~rvalid;

  // --------------------
  // read address
  // --------------------

  // arready is a single-cycle pulse
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      arready <= 1'b0;
    else
      arready <= accept;
  end

  // word index latched together with the arready edge
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
      rd_addr <= araddr[addr_lsb +: vram_addr_bits];
  end

  // ram register loads at the close of the arready cycle
  assign rd_en = arready && arvalid && ~rvalid;

  // --------------------
  // read response
  // --------------------

  // rvalid rises together with the ram output register
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      rvalid <= 1'b0;
      rresp  <= 2'b00;
    end
    else if (rd_en)
    begin
      rvalid <= 1'b1;
      rresp  <= resp_okay;
    end
    else if (rvalid && rready)
      rvalid <= 1'b0;
  end

  // --------------------
  // checks
  // --------------------

  // no address is taken while read data is still waiting
  a_no_ar_pending: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(arready) |-> !$past(rvalid) && !rvalid);

  // read data stays valid until the master takes it
  a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

//--- verilog/vram.sv
`timescale 1ns/10ps
`default_nettype none

module vram import vram_pkg::*;
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  // host write port, byte masked
  input  logic                      wr_en,
  input  logic [vram_addr_bits-1:0] wr_addr,
  input  logic [axi_data_width-1:0] wr_data,
  input  logic [axi_strb_width-1:0] wr_strb,
  // host read port
  input  logic                      rd_en,
  input  logic [vram_addr_bits-1:0] rd_addr,
  output logic [axi_data_width-1:0] host_rdata,
  // display read port, one word per cycle
  input  logic [vram_addr_bits-1:0] display_addr,
  output logic [axi_data_width-1:0] display_data
);

  // inferred block ram, contents undefined until written
  logic [axi_data_width-1:0] mem [0:vram_depth-1];

  // --------------------
  // write port
  // --------------------

  // each enabled lane writes its own byte
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (wr_en)
    begin
      for (int i = 0; i < axi_strb_width; i++)
      begin
        if (wr_strb[i])
          mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
  end

  // --------------------
  // read ports
  // --------------------

  // host register only moves on rd_en so RDATA holds under back-pressure
  // read before write, a same-edge write shows up one access later
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      host_rdata <= '0;
    else if (rd_en)
      host_rdata <= mem[rd_addr];
  end

  // display register loads every cycle, latency of 1
  // same read-before-write rule as the host side
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      display_data <= '0;
    else
      display_data <= mem[display_addr];
  end

endmodule

`default_nettype wire

//--- verilog/hdmi_text_vram_axi.sv
`timescale 1ns/10ps
`default_nettype none

module hdmi_text_vram_axi import vram_pkg::*;
(
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  // write address channel
  input  logic [axi_addr_width-1:0] S_AXI_AWADDR,
  input  logic                      S_AXI_AWVALID,
  output logic                      S_AXI_AWREADY,
  // write data channel
  input  logic [axi_data_width-1:0] S_AXI_WDATA,
  input  logic [axi_strb_width-1:0] S_AXI_WSTRB,
  input  logic                      S_AXI_WVALID,
  output logic                      S_AXI_WREADY,
  // write response channel
  output logic [1:0]                S_AXI_BRESP,
  output logic                      S_AXI_BVALID,
  input  logic                      S_AXI_BREADY,
  // read address channel
  input  logic [axi_addr_width-1:0] S_AXI_ARADDR,
  input  logic                      S_AXI_ARVALID,
  output logic                      S_AXI_ARREADY,
  // read data channel
  output logic [axi_data_width-1:0] S_AXI_RDATA,
  output logic [1:0]                S_AXI_RRESP,
  output logic                      S_AXI_RVALID,
  input  logic                      S_AXI_RREADY,
  // display pipeline fetch port
  input  logic [vram_addr_bits-1:0] display_addr,
  output logic [axi_data_width-1:0] display_data
);

  // --------------------
  // internal nets
  // --------------------

  // write path into the ram
  logic                      wr_en;
  logic [vram_addr_bits-1:0] wr_addr;
  logic [axi_data_width-1:0] wr_data;
  logic [axi_strb_width-1:0] wr_strb;
  // read path into the ram
  logic                      rd_en;
  logic [vram_addr_bits-1:0] rd_addr;
  // registered host word back out to the bus
  logic [axi_data_width-1:0] host_rdata;

  // --------------------
  // channels
  // --------------------

  axi_write_channel i_axi_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wstrb         (S_AXI_WSTRB),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  axi_read_channel i_axi_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr)
  );

  // --------------------
  // memory
  // --------------------

  vram i_vram (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .host_rdata    (host_rdata),
    .display_addr  (display_addr),
    .display_data  (display_data)
  );

  // ram register already holds until the next rd_en
  assign S_AXI_RDATA = host_rdata;

endmodule

`default_nettype wire

//--- bench/tb_hdmi_text_vram_axi.sv
`timescale 1ns/10ps
`default_nettype none

module tb_hdmi_text_vram_axi import vram_pkg::*;
();

  // about 300 transactions at under 20 cycles each, plus margin
  localparam int cycle_limit = 20000;
  localparam int n_basic     = 48;
  localparam int n_strobe    = 48;
  localparam int n_alias     = 24;
  localparam int n_mixed     = 60;
  localparam logic [31:0] seed = 32'h4848;

  logic                      S_AXI_ACLK = 1'b0;
  logic                      S_AXI_ARESETN;
  logic [axi_addr_width-1:0] S_AXI_AWADDR;
  logic                      S_AXI_AWVALID;
  logic                      S_AXI_AWREADY;
  logic [axi_data_width-1:0] S_AXI_WDATA;
  logic [axi_strb_width-1:0] S_AXI_WSTRB;
  logic                      S_AXI_WVALID;
  logic                      S_AXI_WREADY;
  logic [1:0]                S_AXI_BRESP;
  logic                      S_AXI_BVALID;
  logic                      S_AXI_BREADY;
  logic [axi_addr_width-1:0] S_AXI_ARADDR;
  logic                      S_AXI_ARVALID;
  logic                      S_AXI_ARREADY;
  logic [axi_data_width-1:0] S_AXI_RDATA;
  logic [1:0]                S_AXI_RRESP;
  logic                      S_AXI_RVALID;
  logic                      S_AXI_RREADY;
  logic [vram_addr_bits-1:0] display_addr;
  logic [axi_data_width-1:0] display_data;

  // reference vram, known marks the bytes that have been written
  logic [axi_data_width-1:0] model [0:vram_depth-1];
  logic [axi_strb_width-1:0] known [0:vram_depth-1];
  // expected words with the byte masks they are valid under
  logic [axi_data_width-1:0] exp_rdata;
  logic [axi_data_width-1:0] exp_rmask;
  logic [axi_data_width-1:0] exp_disp;
  logic [axi_data_width-1:0] exp_dmask;
  // previous-edge copies for the latency and hold checks
  logic                      wr_valids_q;
  logic                      arvalid_q;
  logic [axi_data_width-1:0] rdata_q;

  int cycle_count     = 0;
  int value_errors    = 0;
  int protocol_errors = 0;
  int write_count;
  int read_count;
  logic [31:0] main_state;
  logic [31:0] bg_state;

  always #2 S_AXI_ACLK = ~S_AXI_ACLK;

  hdmi_text_vram_axi i_hdmi_text_vram_axi (.*);

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // next value of the stimulus sequence
  function automatic logic [31:0] draw();
    main_state = xorshift32(main_state);
    return main_state;
  endfunction

  // byte address to vram word, bits 11..2
  function automatic logic [vram_addr_bits-1:0] word_index(input logic [axi_addr_width-1:0] a);
    return a[11:2];
  endfunction

  // one 0xff byte per set lane
  function automatic logic [axi_data_width-1:0] lane_mask(input logic [axi_strb_width-1:0] lanes);
    logic [axi_data_width-1:0] m;
    m = '0;
    for (int i = 0; i < axi_strb_width; i++)
    begin
      if (lanes[i])
        m[i*8 +: 8] = 8'hff;
    end
    return m;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge S_AXI_ACLK);
  endtask

  // hold both valids until the readies have been seen, drop them after the handshake edge
  task automatic write_word(input logic [axi_addr_width-1:0] addr,
                            input logic [axi_data_width-1:0] data,
                            input logic [axi_strb_width-1:0] strb);
    S_AXI_AWADDR  = addr;
    S_AXI_WDATA   = data;
    S_AXI_WSTRB   = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_AWREADY)
      @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    write_count++;
  endtask

  task automatic read_word(input logic [axi_addr_width-1:0] addr);
    S_AXI_ARADDR  = addr;
    S_AXI_ARVALID = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_ARREADY)
      @(negedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARVALID = 1'b0;
    read_count++;
  endtask

  // --------------------
  // reference model
  // --------------------

  always @(posedge S_AXI_ACLK)
  begin : model_update
    logic [vram_addr_bits-1:0] widx;
    logic [axi_data_width-1:0] wmask;
    widx  = word_index(S_AXI_AWADDR);
    wmask = lane_mask(S_AXI_WSTRB);
    wr_valids_q <= S_AXI_AWVALID && S_AXI_WVALID;
    arvalid_q   <= S_AXI_ARVALID;
    rdata_q     <= S_AXI_RDATA;
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < vram_depth; i++)
        known[i] <= '0;
      exp_rmask <= '0;
      exp_dmask <= '0;
    end
    else
    begin
      // write lands on the handshake edge
      if (S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID)
      begin
        model[widx] <= (model[widx] & ~wmask) | (S_AXI_WDATA & wmask);
        known[widx] <= known[widx] | S_AXI_WSTRB;
      end
      // old word on a same-edge write, read before write
      if (S_AXI_ARREADY && S_AXI_ARVALID)
      begin
        exp_rdata <= model[word_index(S_AXI_ARADDR)];
        exp_rmask <= lane_mask(known[word_index(S_AXI_ARADDR)]);
      end
      exp_disp  <= model[display_addr];
      exp_dmask <= lane_mask(known[display_addr]);
    end
  end

  // --------------------
  // checks
  // --------------------

  a_reset_quiet: assert property (@(posedge S_AXI_ACLK)
    cycle_count > 0 && $past(!S_AXI_ARESETN) |-> !S_AXI_AWREADY && !S_AXI_WREADY &&
      !S_AXI_BVALID && !S_AXI_ARREADY && !S_AXI_RVALID)
    else
    begin
      protocol_errors++;
      $display("handshake output high during or right after reset, cycle %0d", cycle_count);
    end

  a_bresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID |-> S_AXI_BRESP == resp_okay)
    else
    begin
      value_errors++;
      $display("[ERROR] S_AXI_BRESP expected %h actual %h", resp_okay, $sampled(S_AXI_BRESP));
    end

  a_rresp_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID |-> S_AXI_RRESP == resp_okay)
    else
    begin
      value_errors++;
      $display("[ERROR] S_AXI_RRESP expected %h actual %h", resp_okay, $sampled(S_AXI_RRESP));
    end

  // both valids rising on an idle slave give BVALID two edges later
  a_b_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $past(S_AXI_AWVALID && S_AXI_WVALID && !wr_valids_q && !S_AXI_AWREADY &&
      !S_AXI_BVALID, 2) |-> S_AXI_BVALID && !$past(S_AXI_BVALID))
    else
    begin
      protocol_errors++;
      $display("write response did not arrive 2 cycles after the write, cycle %0d", cycle_count);
    end

  a_r_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $past(S_AXI_ARVALID && !arvalid_q && !S_AXI_ARREADY && !S_AXI_RVALID, 2) |->
      S_AXI_RVALID && !$past(S_AXI_RVALID))
    else
    begin
      protocol_errors++;
      $display("read data did not arrive 2 cycles after the address, cycle %0d", cycle_count);
    end

  a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
    else
    begin
      protocol_errors++;
      $display("write response dropped before it was taken, cycle %0d", cycle_count);
    end

  // one outstanding write, new valids are ignored while the response waits
  a_write_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_BVALID |-> !S_AXI_AWREADY && !S_AXI_WREADY)
    else
    begin
      protocol_errors++;
      $display("write accepted while a response was pending, cycle %0d", cycle_count);
    end

  a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
    else
    begin
      protocol_errors++;
      $display("read data dropped before it was taken, cycle %0d", cycle_count);
    end

  a_rdata_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RDATA == rdata_q)
    else
    begin
      value_errors++;
      $display("[ERROR] S_AXI_RDATA expected %h actual %h", $sampled(rdata_q),
        $sampled(S_AXI_RDATA));
    end

  // only bytes the model knows are compared
  a_rdata_model: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    S_AXI_RVALID |-> (S_AXI_RDATA & exp_rmask) == (exp_rdata & exp_rmask))
    else
    begin
      value_errors++;
      $display("[ERROR] S_AXI_RDATA expected %h actual %h mask %h", $sampled(exp_rdata),
        $sampled(S_AXI_RDATA), $sampled(exp_rmask));
    end

  a_display_model: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (display_data & exp_dmask) == (exp_disp & exp_dmask))
    else
    begin
      value_errors++;
      $display("[ERROR] display_data expected %h actual %h mask %h", $sampled(exp_disp),
        $sampled(display_data), $sampled(exp_dmask));
    end

  // --------------------
  // run control
  // --------------------

  always @(posedge S_AXI_ACLK)
  begin
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout, run still busy after %0d cycles", cycle_count);
      $display("ERRORS FOUND");
      $finish;
    end
    else
      cycle_count <= cycle_count + 1;
  end

  // response readies low most of the time, display address moves every cycle
  // half the time the display follows the write address, so it meets same-edge writes
  initial
  begin : ready_and_display
    S_AXI_BREADY = 1'b0;
    S_AXI_RREADY = 1'b0;
    display_addr = '0;
    bg_state     = {seed[15:0], seed[31:16]};
    forever
    begin
      @(negedge S_AXI_ACLK);
      bg_state     = xorshift32(bg_state);
      S_AXI_BREADY = (bg_state[1:0] == 2'b00);
      S_AXI_RREADY = (bg_state[3:2] == 2'b00);
      if (bg_state[4])
        display_addr = word_index(S_AXI_AWADDR);
      else
        display_addr = bg_state[21:12];
    end
  end

  initial
  begin : main_sequence
    logic [31:0]               r;
    logic [31:0]               d;
    logic [axi_addr_width-1:0] addr;
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WSTRB   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_ARADDR  = '0;
    S_AXI_ARVALID = 1'b0;
    main_state    = seed;
    write_count   = 0;
    read_count    = 0;
    repeat (5) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    idle(2);

    // full word write, then read back
    for (int i = 0; i < n_basic; i++)
    begin
      r = draw();
      d = draw();
      write_word(r[15:0], d, 4'hf);
      idle(1 + int'(r[17:16]));
      read_word(r[15:0]);
      idle(1);
    end

    // partial strobes over earlier contents
    for (int i = 0; i < n_strobe; i++)
    begin
      r = draw();
      d = draw();
      write_word({r[15:12], 4'h0, r[7:0]}, d, r[27:24]);
      idle(1);
      read_word({r[15:12], 4'h0, r[7:0]});
      idle(1 + int'(r[29:28]));
    end

    // aliases above bit 11 on even passes, in bits 1..0 on odd passes
    for (int i = 0; i < n_alias; i++)
    begin
      r = draw();
      d = draw();
      write_word(r[15:0], d, 4'hf);
      idle(1);
      if (i % 2 == 0)
        addr = r[15:0] ^ {r[19:16] | 4'h1, 12'h000};
      else
        addr = r[15:0] ^ {14'h0000, r[17:16] | 2'b01};
      read_word(addr);
      idle(1);
    end

    // back to back mix, new valids meet a pending response
    for (int i = 0; i < n_mixed; i++)
    begin
      r = draw();
      d = draw();
      if (r[31])
        write_word(r[15:0], d, r[19:16]);
      else
        read_word({r[15:12], 4'h0, r[7:0]});
    end

    while (S_AXI_BVALID || S_AXI_RVALID)
      @(negedge S_AXI_ACLK);
    idle(3);

    $display("writes %0d reads %0d cycles %0d value errors %0d protocol errors %0d",
      write_count, read_count, cycle_count, value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
verilog/vram_pkg.sv
verilog/axi_write_channel.sv
verilog/axi_read_channel.sv
verilog/vram.sv
verilog/hdmi_text_vram_axi.sv
bench/tb_hdmi_text_vram_axi.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it into a log and judge the log.

cd "$(dirname "$0")" || exit 1

top=tb_hdmi_text_vram_axi
obj=obj_dir
log=sim.log

verilator --binary --timing --assert \
  --top-module "$top" \
  -Mdir "$obj" \
  -f all.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$obj/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
  echo "simulation reported failures, see $log"
  exit 1
fi

echo "simulation passed"
exit 0
